// File: framer_top.f
rtl/frame_pkg.sv
rtl/stream_fifo.sv
rtl/sample_packer.sv
rtl/cycle_counter.sv
rtl/frame_header_inserter.sv
rtl/framer_top.sv
testbench/tb_framer_top.sv

// File: run_sim.sh
#!/bin/sh
# Builds the framer testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_framer_top \
    --Mdir obj_dir -o sim_framer \
    -f framer_top.f

./obj_dir/sim_framer > sim.log 2>&1
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

// File: testbench/tb_framer_top.sv
// ##################################################
// testbench for the sample framer: sends whole frames of random samples
// and checks every output beat against a reference model of the framing.
// ##################################################

`timescale 1ns/1ps

module tb_framer_top;

    import frame_pkg::*;

    localparam int RESET_CYCLES    = 16;
    // all samples of all tests, two per data word.
    localparam int TOTAL_SAMPLES   = 2 * (6*4 + 8*6 + 10*1 + 2*256 + 3*3 + 2*7);
    localparam int WATCHDOG_CYCLES = TOTAL_SAMPLES * 20 + 2000;

    logic                    clk;
    logic                    sync_reset;
    logic                    s_valid;
    logic [SAMPLE_WIDTH-1:0] s_data;
    logic                    s_ready;
    logic [COUNT_WIDTH-1:0]  cnt_limit;
    logic                    m_valid;
    out_beat_t               m_data;
    logic                    m_ready;

    integer                  seed = 32'h83016913;
    bit                      stall_en;
    int                      errors;
    int                      tests_failed;
    logic [SAMPLE_WIDTH-1:0] samples[$];
    out_beat_t               exp_q[$];

    framer_top i_dut (
        .clk       (clk),
        .sync_reset(sync_reset),
        .s_valid   (s_valid),
        .s_data    (s_data),
        .s_ready   (s_ready),
        .cnt_limit (cnt_limit),
        .m_valid   (m_valid),
        .m_data    (m_data),
        .m_ready   (m_ready)
    );

    always #5 clk = ~clk;

    // reference model: one header beat, then limit plus one data words per frame.
    function automatic void build_expected(input int limit, input int n_frames,
                                           input int first_seq);
        int        word_idx;
        out_beat_t beat;
        word_idx = 0;
        for (int f = 0; f < n_frames; f++) begin
            beat = '0;
            beat.header = 1'b1;
            beat.data[HDR_SEQ_LSB +: SEQ_WIDTH] = SEQ_WIDTH'(first_seq + f);
            beat.data[HDR_LEN_LSB +: LEN_WIDTH] = LEN_WIDTH'(limit + 1);
            exp_q.push_back(beat);
            for (int w = 0; w <= limit; w++) begin
                beat = '0;
                beat.last = (w == limit);
                beat.data = {samples[2*word_idx+1], samples[2*word_idx]};
                exp_q.push_back(beat);
                word_idx++;
            end
        end
    endfunction

    task automatic compare_beat(input out_beat_t got);
        out_beat_t exp;
        assert (exp_q.size() != 0) else begin
            $display("at %0t the DUT sent beat %h, but no beat was expected", $time, got);
            errors++;
        end
        if (exp_q.size() != 0) begin
            exp = exp_q.pop_front();
            assert (got.header == exp.header) else begin
                $display("Error: time %0t, m_data.header expected %0b, got %0b",
                         $time, exp.header, got.header);
                errors++;
            end
            assert (got.last == exp.last) else begin
                $display("Error: time %0t, m_data.last expected %0b, got %0b",
                         $time, exp.last, got.last);
                errors++;
            end
            assert (got.data == exp.data) else begin
                $display("Error: time %0t, m_data.data expected %h, got %h",
                         $time, exp.data, got.data);
                errors++;
            end
        end
    endtask

    // the output side settles 1 ns after the falling edge and holds until the rising one.
    always begin
        @(negedge clk);
        m_ready = stall_en ? (($random(seed) & 3) != 0) : 1'b1;
        #1;
        if (!sync_reset && m_valid && m_ready) begin
            compare_beat(m_data);
        end
    end

    task automatic apply_reset();
        @(negedge clk);
        sync_reset = 1'b1;
        s_valid    = 1'b0;
        exp_q.delete();
        repeat (RESET_CYCLES) @(negedge clk);
        sync_reset = 1'b0;
        #1;
        assert (!s_ready && !m_valid) else begin
            $display("at %0t the DUT was ready or valid in the first cycle after reset", $time);
            errors++;
        end
    endtask

    // a sample stays on the input until it is taken; gaps only come between samples.
    task automatic send_samples(input bit gaps);
        int idx;
        bit accepted;
        idx      = 0;
        accepted = 1'b0;
        while (idx < samples.size()) begin
            @(negedge clk);
            if (accepted) begin
                s_valid = 1'b0;
            end
            if (!s_valid && (!gaps || (($random(seed) & 3) != 0))) begin
                s_valid = 1'b1;
                s_data  = samples[idx];
            end
            #1;
            accepted = s_valid && s_ready;
            if (accepted) begin
                idx++;
            end
        end
        @(negedge clk);
        s_valid = 1'b0;
    endtask

    task automatic wait_drain(input int max_cycles);
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < max_cycles) begin
            @(negedge clk);
            cycles++;
        end
        // a few more cycles so that a surplus beat is caught as well.
        repeat (20) @(negedge clk);
        assert (exp_q.size() == 0) else begin
            $display("%0d expected beats never left the DUT", exp_q.size());
            errors++;
        end
    endtask

    task automatic run_frames(input int limit, input int n_frames, input int first_seq,
                              input bit gaps);
        @(negedge clk);
        cnt_limit = COUNT_WIDTH'(limit);
        samples.delete();
        repeat (2 * n_frames * (limit + 1)) begin
            samples.push_back(SAMPLE_WIDTH'($random(seed)));
        end
        build_expected(limit, n_frames, first_seq);
        send_samples(gaps);
        wait_drain(samples.size() * 20 + 200);
    endtask

    task automatic report_test(input int num, input string name, input int errs_before);
        if (errors == errs_before) begin
            $display("test %0d (%s): passed", num, name);
        end else begin
            $display("test %0d (%s): failed with %0d errors", num, name, errors - errs_before);
            tests_failed++;
        end
    endtask

    initial begin
        int errs_before;
        clk          = 1'b0;
        sync_reset   = 1'b1;
        s_valid      = 1'b0;
        s_data       = '0;
        cnt_limit    = '0;
        m_ready      = 1'b0;
        stall_en     = 1'b0;
        errors       = 0;
        tests_failed = 0;

        errs_before = errors;
        apply_reset();
        run_frames(3, 6, 0, 1'b0);
        report_test(1, "limit 3, steady flow", errs_before);

        errs_before = errors;
        apply_reset();
        stall_en = 1'b1;
        run_frames(5, 8, 0, 1'b1);
        stall_en = 1'b0;
        report_test(2, "limit 5, random gaps and stalls", errs_before);

        errs_before = errors;
        apply_reset();
        run_frames(0, 10, 0, 1'b0);
        report_test(3, "limit 0, one word per frame", errs_before);

        errs_before = errors;
        apply_reset();
        run_frames(255, 2, 0, 1'b0);
        report_test(4, "limit 255, longest frames", errs_before);

        // the second limit is taken without reset, so the sequence runs on.
        errs_before = errors;
        apply_reset();
        run_frames(2, 3, 0, 1'b0);
        run_frames(6, 2, 3, 1'b0);
        report_test(5, "limit change between frames", errs_before);

        $display("5 tests run, %0d failed, %0d errors", tests_failed, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// File: rtl/framer_top.sv
// ################################################
// // top level of the sample framer: packer, counter and header
// // inserter chained by valid/ready streams.
// ################################################

`timescale 1ns/1ps

module framer_top #(
    parameter int CNT_FIFO_DEPTH = 8,
    parameter int CNT_AF_THRESH  = 6,
    parameter int OUT_DEPTH      = 4
) (
    input  logic                              clk,
    input  logic                              sync_reset,

    input  logic                              s_valid,
    input  logic [frame_pkg::SAMPLE_WIDTH-1:0] s_data,
    output logic                              s_ready,

    input  logic [frame_pkg::COUNT_WIDTH-1:0]  cnt_limit,

    output logic                              m_valid,
    output frame_pkg::out_beat_t              m_data,
    input  logic                              m_ready
);

    import frame_pkg::*;

    // packed words from the packer to the counter.
    logic                  packed_valid;
    logic [WORD_WIDTH-1:0] packed_data;
    logic                  packed_ready;

    // tagged words from the counter to the header inserter.
    logic                  tagged_valid;
    tagged_word_t          tagged_data;
    logic                  tagged_ready;

    sample_packer u_packer (
        .clk       (clk),
        .sync_reset(sync_reset),
        .s_valid   (s_valid),
        .s_data    (s_data),
        .s_ready   (s_ready),
        .m_valid   (packed_valid),
        .m_data    (packed_data),
        .m_ready   (packed_ready)
    );

    cycle_counter #(
        .FIFO_DEPTH    (CNT_FIFO_DEPTH),
        .FIFO_AF_THRESH(CNT_AF_THRESH)
    ) u_counter (
        .clk       (clk),
        .sync_reset(sync_reset),
        .s_valid   (packed_valid),
        .s_data    (packed_data),
        .cnt_limit (cnt_limit),
        .s_ready   (packed_ready),
        .m_valid   (tagged_valid),
        .m_data    (tagged_data),
        .m_ready   (tagged_ready)
    );

    frame_header_inserter #(
        .OUT_DEPTH(OUT_DEPTH)
    ) u_inserter (
        .clk       (clk),
        .sync_reset(sync_reset),
        .s_valid   (tagged_valid),
        .s_data    (tagged_data),
        .s_ready   (tagged_ready),
        .m_valid   (m_valid),
        .m_data    (m_data),
        .m_ready   (m_ready)
    );

endmodule

// File: rtl/frame_header_inserter.sv
// ################################################
// // output stage: puts a header beat with sequence number and length
// // in front of every frame and marks the last beat.
// ################################################

`timescale 1ns/1ps

module frame_header_inserter #(
    parameter int OUT_DEPTH = 4
) (
    input  logic                    clk,
    input  logic                    sync_reset,

    input  logic                    s_valid,
    input  frame_pkg::tagged_word_t s_data,
    output logic                    s_ready,

    output logic                    m_valid,
    output frame_pkg::out_beat_t    m_data,
    input  logic                    m_ready
);

    import frame_pkg::*;

    logic                  frame_open;
    logic                  header_sent;
    logic                  hdr_needed;
    logic                  out_ready;
    logic                  hdr_push;
    logic                  word_take;
    logic [SEQ_WIDTH-1:0]  seq_num;
    logic [LEN_WIDTH-1:0]  frame_len;
    logic [WORD_WIDTH-1:0] header_word;
    out_beat_t             push_beat;

    // a header is due when no frame is open and none has gone out yet
    // for the word now waiting at the input.
    assign hdr_needed = ~frame_open & ~header_sent;

    assign s_ready   = out_ready & ~hdr_needed;
    assign hdr_push  = s_valid & out_ready & hdr_needed;
    assign word_take = s_valid & s_ready;

    // the first word of a frame carries the reloaded limit as its count.
    assign frame_len = LEN_WIDTH'(s_data.count) + LEN_WIDTH'(1);

    always_comb begin
        header_word = '0;
        header_word[HDR_SEQ_LSB +: SEQ_WIDTH] = seq_num;
        header_word[HDR_LEN_LSB +: LEN_WIDTH] = frame_len;
    end

    always_comb begin
        if (hdr_needed) begin
            push_beat.header = 1'b1;
            push_beat.last   = 1'b0;
            push_beat.data   = header_word;
        end else begin
            push_beat.header = 1'b0;
            push_beat.last   = s_data.final_cnt;
            push_beat.data   = s_data.data;
        end
    end

    always_ff @(posedge clk) begin
        if (sync_reset) begin
            frame_open  <= 1'b0;
            header_sent <= 1'b0;
            seq_num     <= '0;
        end else begin
            if (hdr_push) begin
                header_sent <= 1'b1;
            end
            if (word_take) begin
                header_sent <= 1'b0;
                frame_open  <= ~s_data.final_cnt;
                // the sequence number wraps at its full width.
                if (s_data.final_cnt) begin
                    seq_num <= seq_num + 1'b1;
                end
            end
        end
    end

    // the push is offered whenever a tagged word waits. the beat type
    // is chosen by hdr_needed, so headers and words share one write port.
    stream_fifo #(
        .payload_t         (out_beat_t),
        .DEPTH             (OUT_DEPTH),
        .ALMOST_FULL_THRESH(OUT_DEPTH)
    ) u_out_fifo (
        .clk        (clk),
        .sync_reset (sync_reset),
        .s_valid    (s_valid),
        .s_data     (push_beat),
        .s_ready    (out_ready),
        .almost_full(),
        .m_valid    (m_valid),
        .m_data     (m_data),
        .m_ready    (m_ready)
    );

endmodule

// File: rtl/cycle_counter.sv
// ################################################
// // tags each accepted word with a down-count from cnt_limit to zero
// // and buffers the tagged words in a FIFO with almost-full back-pressure.
// ################################################

`timescale 1ns/1ps

module cycle_counter #(
    parameter int FIFO_DEPTH     = 8,
    parameter int FIFO_AF_THRESH = 6
) (
    input  logic                             clk,
    input  logic                             sync_reset,

    input  logic                             s_valid,
    input  logic [frame_pkg::WORD_WIDTH-1:0]  s_data,
    input  logic [frame_pkg::COUNT_WIDTH-1:0] cnt_limit,
    output logic                             s_ready,

    output logic                             m_valid,
    output frame_pkg::tagged_word_t          m_data,
    input  logic                             m_ready
);

    import frame_pkg::*;

    logic                   almost_full;
    logic                   take;
    logic                   startup;
    logic [COUNT_WIDTH-1:0] count_q;
    logic [COUNT_WIDTH-1:0] count_next;
    logic [WORD_WIDTH-1:0]  data_d0;
    logic                   take_d0;
    tagged_word_t           fifo_word;

    // the threshold sits below full, so the word still in the delay
    // register always finds a free slot.
    assign s_ready = ~almost_full;
    assign take    = s_valid & s_ready;

    // a new frame begins after reset and after every word that hit zero.
    // the limit is sampled only at that point.
    always_comb begin
        if (startup || (count_q == '0)) begin
            count_next = cnt_limit;
        end else begin
            count_next = count_q - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (sync_reset) begin
            startup <= 1'b1;
            take_d0 <= 1'b0;
        end else begin
            take_d0 <= take;
            if (take) begin
                startup <= 1'b0;
                count_q <= count_next;
            end
        end
    end

    // count_q always belongs to the word in the delay register.
    always_ff @(posedge clk) begin
        if (take) begin
            data_d0 <= s_data;
        end
    end

    always_comb begin
        fifo_word.final_cnt = (count_q == '0);
        fifo_word.count     = count_q;
        fifo_word.data      = data_d0;
    end

    // the almost-full flag guards the FIFO, so its own ready stays open.
    stream_fifo #(
        .payload_t         (tagged_word_t),
        .DEPTH             (FIFO_DEPTH),
        .ALMOST_FULL_THRESH(FIFO_AF_THRESH)
    ) u_fifo (
        .clk        (clk),
        .sync_reset (sync_reset),
        .s_valid    (take_d0),
        .s_data     (fifo_word),
        .s_ready    (),
        .almost_full(almost_full),
        .m_valid    (m_valid),
        .m_data     (m_data),
        .m_ready    (m_ready)
    );

endmodule

// File: rtl/sample_packer.sv
// ################################################
// // input stage: joins two 16-bit samples into one 32-bit word,
// // first sample in the low half.
// ################################################

`timescale 1ns/1ps

module sample_packer (
    input  logic                              clk,
    input  logic                              sync_reset,

    input  logic                              s_valid,
    input  logic [frame_pkg::SAMPLE_WIDTH-1:0] s_data,
    output logic                              s_ready,

    output logic                              m_valid,
    output logic [frame_pkg::WORD_WIDTH-1:0]   m_data,
    input  logic                              m_ready
);

    import frame_pkg::*;

    logic                    in_enable;
    logic                    high_half;
    logic [SAMPLE_WIDTH-1:0] low_sample;
    logic [WORD_WIDTH-1:0]   word_q;
    logic                    word_valid;
    logic                    take;

    // the input opens one cycle after reset is released. after that it
    // follows the output register, so at most one word and one pending
    // sample are held under back-pressure.
    assign s_ready = in_enable & (~word_valid | m_ready);
    assign take    = s_valid & s_ready;

    assign m_valid = word_valid;
    assign m_data  = word_q;

    always_ff @(posedge clk) begin
        if (sync_reset) begin
            in_enable  <= 1'b0;
            high_half  <= 1'b0;
            word_valid <= 1'b0;
        end else begin
            in_enable <= 1'b1;
            if (take) begin
                high_half <= ~high_half;
            end
            if (take && high_half) begin
                word_valid <= 1'b1;
            end else if (m_ready) begin
                word_valid <= 1'b0;
            end
        end
    end

    // the low sample waits here until its partner arrives.
    always_ff @(posedge clk) begin
        if (take && !high_half) begin
            low_sample <= s_data;
        end
        if (take && high_half) begin
            word_q <= {s_data, low_sample};
        end
    end

endmodule

// File: rtl/stream_fifo.sv
// ################################################
// // synchronous valid/ready FIFO for any packed payload type,
// // with an almost-full level for early back-pressure.
// ################################################

`timescale 1ns/1ps

module stream_fifo #(
    parameter type payload_t          = logic [31:0],
    parameter int  DEPTH              = 8,
    parameter int  ALMOST_FULL_THRESH = 6
) (
    input  logic     clk,
    input  logic     sync_reset,

    input  logic     s_valid,
    input  payload_t s_data,
    output logic     s_ready,

    output logic     almost_full,

    output logic     m_valid,
    output payload_t m_data,
    input  logic     m_ready
);

    localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int OCC_WIDTH = $clog2(DEPTH + 1);

    payload_t             mem [DEPTH];
    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH-1:0] rd_ptr;
    logic [OCC_WIDTH-1:0] occupancy;
    logic                 wr_en;
    logic                 rd_en;

    // pointers wrap at DEPTH, which need not be a power of two.
    function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
        if (ptr == PTR_WIDTH'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign s_ready     = (occupancy != OCC_WIDTH'(DEPTH));
    assign almost_full = (occupancy >= OCC_WIDTH'(ALMOST_FULL_THRESH));
    assign m_valid     = (occupancy != '0);
    assign m_data      = mem[rd_ptr];

    assign wr_en = s_valid & s_ready;
    assign rd_en = m_valid & m_ready;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= s_data;
        end
    end

    always_ff @(posedge clk) begin
        if (sync_reset) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            occupancy <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (rd_en) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // a write and a read in the same cycle leave the level as it is.
            case ({wr_en, rd_en})
                2'b10:   occupancy <= occupancy + 1'b1;
                2'b01:   occupancy <= occupancy - 1'b1;
                default: occupancy <= occupancy;
            endcase
        end
    end

endmodule

// File: rtl/frame_pkg.sv
// ################################################
// // shared widths, stream payload structs and the header word layout
// // for the sample framer. import it wherever these types are needed.
// ################################################

package frame_pkg;

    // input sample and packed word widths.
    localparam int SAMPLE_WIDTH = 16;
    localparam int WORD_WIDTH   = 32;

    // the down-count and the programmable limit share one width.
    localparam int COUNT_WIDTH  = 8;

    // header fields. the length holds limit plus one, so up to 256.
    localparam int SEQ_WIDTH    = 16;
    localparam int LEN_WIDTH    = 9;

    // header word layout.
    // the sequence number sits at the bottom, the length above it,
    // and every bit above the length is zero.
    localparam int HDR_SEQ_LSB  = 0;
    localparam int HDR_LEN_LSB  = 16;

    // a packed word tagged with its position in the frame.
    // final_cnt is set on the word whose count has reached zero.
    typedef struct packed {
        logic                   final_cnt;
        logic [COUNT_WIDTH-1:0] count;
        logic [WORD_WIDTH-1:0]  data;
    } tagged_word_t;

    // one beat of the framed output stream.
    typedef struct packed {
        logic                  header;
        logic                  last;
        logic [WORD_WIDTH-1:0] data;
    } out_beat_t;

endpackage
